// File: mips_consts.svh
`ifndef MIPS_CONSTS_SVH
`define MIPS_CONSTS_SVH

// First instruction fetch address after reset.
`define MIPS_RESET_VECTOR 32'hBFC00000

// A jump or branch to this address stops the core.
`define MIPS_HALT_ADDR 32'h00000000

// Register exported on register_v0.
`define MIPS_REG_V0 5'd2

// Data and address width.
`define MIPS_WORD_W 32

`endif

// File: mips_pkg.sv
package mips_pkg;

    // Decoded operation, one per supported instruction.
    typedef enum logic [4:0] {
        OP_ADDU    = 5'd0,
        OP_SUBU    = 5'd1,
        OP_AND     = 5'd2,
        OP_OR      = 5'd3,
        OP_XOR     = 5'd4,
        OP_SLT     = 5'd5,
        OP_SLTU    = 5'd6,
        OP_SLL     = 5'd7,
        OP_SRL     = 5'd8,
        OP_JR      = 5'd9,
        OP_ADDIU   = 5'd10,
        OP_ANDI    = 5'd11,
        OP_ORI     = 5'd12,
        OP_XORI    = 5'd13,
        OP_LUI     = 5'd14,
        OP_LW      = 5'd15,
        OP_SW      = 5'd16,
        OP_BEQ     = 5'd17,
        OP_BNE     = 5'd18,
        OP_J       = 5'd19,
        OP_INVALID = 5'd31
    } opcode_t;

    // Multicycle sequencer states.
    typedef enum logic [2:0] {
        ST_FETCH     = 3'd0,
        ST_DECODE    = 3'd1,
        ST_EXEC      = 3'd2,
        ST_WRITEBACK = 3'd3,
        ST_HALT      = 3'd4
    } cpu_state_t;

endpackage

// File: cpu_control.sv
`timescale 1ns/1ps
`include "mips_consts.svh"

module cpu_control (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 bus_busy,
    input  logic                 halt_req,
    output mips_pkg::cpu_state_t state,
    output logic                 halted
);
    import mips_pkg::*;

    cpu_state_t state_nxt;

    always_comb begin
        state_nxt = state;
        case (state)
            ST_FETCH:     if (!bus_busy) state_nxt = ST_DECODE;
            ST_DECODE:    state_nxt = ST_EXEC;
            ST_EXEC:      if (!bus_busy) state_nxt = ST_WRITEBACK;
            ST_WRITEBACK: state_nxt = halt_req ? ST_HALT : ST_FETCH; // Stop on jump to zero.
            ST_HALT:      state_nxt = ST_HALT;                       // Only reset leaves.
            default:      state_nxt = ST_FETCH;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= ST_FETCH;
        end else begin
            state <= state_nxt;
        end
    end

    assign halted = (state == ST_HALT);

endmodule

// File: instr_decode.sv
`timescale 1ns/1ps
`include "mips_consts.svh"

module instr_decode (
    input  logic                    clk,
    input  logic                    rst_n,
    input  mips_pkg::cpu_state_t    state,
    input  logic [`MIPS_WORD_W-1:0] readdata,
    output mips_pkg::opcode_t       opcode,
    output logic [4:0]              rs_idx,
    output logic [4:0]              rt_idx,
    output logic [4:0]              wb_idx,
    output logic                    wb_en,
    output logic [`MIPS_WORD_W-1:0] imm_sext,
    output logic [`MIPS_WORD_W-1:0] imm_zext,
    output logic [4:0]              shamt,
    output logic [25:0]             jump_index
);
    import mips_pkg::*;

    logic [`MIPS_WORD_W-1:0] ir;
    logic [5:0]              op_f, funct_f;
    logic                    r_type, writes_reg;

    // Fetched word is on readdata during decode.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ir <= '0; // Decodes as SLL r0, a no-op.
        end else if (state == ST_DECODE) begin
            ir <= readdata;
        end
    end

    assign op_f       = ir[31:26];
    assign funct_f    = ir[5:0];
    assign r_type     = (op_f == 6'h00);
    assign rs_idx     = ir[25:21];
    assign rt_idx     = ir[20:16];
    assign wb_idx     = r_type ? ir[15:11] : ir[20:16];
    assign shamt      = ir[10:6];
    assign jump_index = ir[25:0];
    assign imm_sext   = {{16{ir[15]}}, ir[15:0]};
    assign imm_zext   = {16'h0000, ir[15:0]};

    always_comb begin
        opcode = OP_INVALID;
        case (op_f)
            6'h00: begin
                case (funct_f)
                    6'h21:   opcode = OP_ADDU;
                    6'h23:   opcode = OP_SUBU;
                    6'h24:   opcode = OP_AND;
                    6'h25:   opcode = OP_OR;
                    6'h26:   opcode = OP_XOR;
                    6'h2A:   opcode = OP_SLT;
                    6'h2B:   opcode = OP_SLTU;
                    6'h00:   opcode = OP_SLL;
                    6'h02:   opcode = OP_SRL;
                    6'h08:   opcode = OP_JR;
                    default: opcode = OP_INVALID;
                endcase
            end
            6'h09:   opcode = OP_ADDIU;
            6'h0C:   opcode = OP_ANDI;
            6'h0D:   opcode = OP_ORI;
            6'h0E:   opcode = OP_XORI;
            6'h0F:   opcode = OP_LUI;
            6'h23:   opcode = OP_LW;
            6'h2B:   opcode = OP_SW;
            6'h04:   opcode = OP_BEQ;
            6'h05:   opcode = OP_BNE;
            6'h02:   opcode = OP_J;
            default: opcode = OP_INVALID;
        endcase
    end

    // Stores, branches, jumps and unknown words leave the registers alone.
    assign writes_reg = !(opcode inside {OP_JR, OP_SW, OP_BEQ, OP_BNE, OP_J, OP_INVALID});
    assign wb_en      = writes_reg && (wb_idx != 5'd0);

endmodule

// File: mips_alu.sv
`timescale 1ns/1ps
`include "mips_consts.svh"

module mips_alu (
    input  mips_pkg::opcode_t       opcode,
    input  logic [`MIPS_WORD_W-1:0] rs_data,
    input  logic [`MIPS_WORD_W-1:0] rt_data,
    input  logic [`MIPS_WORD_W-1:0] imm_sext,
    input  logic [`MIPS_WORD_W-1:0] imm_zext,
    input  logic [4:0]              shamt,
    output logic [`MIPS_WORD_W-1:0] result,
    output logic                    equal
);
    import mips_pkg::*;

    logic [`MIPS_WORD_W-1:0] op_b;

    always_comb begin
        case (opcode)
            OP_ADDIU, OP_LW, OP_SW:   op_b = imm_sext; // Address offsets too.
            OP_ANDI, OP_ORI, OP_XORI: op_b = imm_zext;
            default:                  op_b = rt_data;
        endcase
    end

    always_comb begin
        case (opcode)
            OP_ADDU, OP_ADDIU, OP_LW, OP_SW: result = rs_data + op_b;
            OP_SUBU:                         result = rs_data - op_b;
            OP_AND, OP_ANDI:                 result = rs_data & op_b;
            OP_OR, OP_ORI:                   result = rs_data | op_b;
            OP_XOR, OP_XORI:                 result = rs_data ^ op_b;
            OP_SLT: begin
                result = {31'd0, $signed(rs_data) < $signed(op_b)};
            end
            OP_SLTU:                         result = {31'd0, rs_data < op_b};
            OP_SLL:                          result = op_b << shamt; // Shifts act on rt.
            OP_SRL:                          result = op_b >> shamt;
            default:                         result = '0;
        endcase
    end

    assign equal = (rs_data == rt_data); // Branch compare.

endmodule

// File: mips_regfile.sv
`timescale 1ns/1ps
`include "mips_consts.svh"

module mips_regfile (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    wr_en,
    input  logic [4:0]              wr_idx,
    input  logic [`MIPS_WORD_W-1:0] wr_data,
    input  logic [4:0]              rd_a_idx,
    input  logic [4:0]              rd_b_idx,
    output logic [`MIPS_WORD_W-1:0] rd_a_data,
    output logic [`MIPS_WORD_W-1:0] rd_b_data,
    output logic [`MIPS_WORD_W-1:0] v0
);

    logic [`MIPS_WORD_W-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_idx != 5'd0)) begin
            regs[wr_idx] <= wr_data; // Register zero stays zero.
        end
    end

    assign rd_a_data = regs[rd_a_idx];
    assign rd_b_data = regs[rd_b_idx];
    assign v0        = regs[`MIPS_REG_V0];

endmodule

// File: pc_unit.sv
`timescale 1ns/1ps
`include "mips_consts.svh"

module pc_unit (
    input  logic                    clk,
    input  logic                    rst_n,
    input  mips_pkg::cpu_state_t    state,
    input  mips_pkg::opcode_t       opcode,
    input  logic [`MIPS_WORD_W-1:0] imm_sext,
    input  logic [25:0]             jump_index,
    input  logic [`MIPS_WORD_W-1:0] rs_data,
    input  logic                    equal,
    output logic [`MIPS_WORD_W-1:0] pc,
    output logic                    halt_req
);
    import mips_pkg::*;

    logic [`MIPS_WORD_W-1:0] pc_plus4, pc_nxt;

    assign pc_plus4 = pc + 32'd4;

    // No delay slot, so targets apply directly.
    always_comb begin
        case (opcode)
            OP_BEQ:  pc_nxt = equal ? pc_plus4 + {imm_sext[29:0], 2'b00} : pc_plus4;
            OP_BNE:  pc_nxt = !equal ? pc_plus4 + {imm_sext[29:0], 2'b00} : pc_plus4;
            OP_J:    pc_nxt = {pc[31:28], jump_index, 2'b00};
            OP_JR:   pc_nxt = rs_data;
            default: pc_nxt = pc_plus4;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= `MIPS_RESET_VECTOR;
        end else if (state == ST_WRITEBACK) begin
            pc <= pc_nxt;
        end
    end

    assign halt_req = (pc_nxt == `MIPS_HALT_ADDR);

endmodule

// File: mem_access.sv
`timescale 1ns/1ps
`include "mips_consts.svh"

module mem_access (
    input  logic                    clk,
    input  logic                    rst_n,
    input  mips_pkg::cpu_state_t    state,
    input  mips_pkg::opcode_t       opcode,
    input  logic [`MIPS_WORD_W-1:0] pc,
    input  logic [`MIPS_WORD_W-1:0] alu_result,
    input  logic [`MIPS_WORD_W-1:0] store_data,
    input  logic                    waitrequest,
    input  logic [`MIPS_WORD_W-1:0] readdata,
    output logic [`MIPS_WORD_W-1:0] address,
    output logic                    read,
    output logic                    write,
    output logic [`MIPS_WORD_W-1:0] writedata,
    output logic [3:0]              byteenable,
    output logic [`MIPS_WORD_W-1:0] load_data,
    output logic                    bus_busy
);
    import mips_pkg::*;

    logic done, accept, mem_op, req_phase;

    assign mem_op    = (state == ST_EXEC) && (opcode == OP_LW || opcode == OP_SW);
    assign req_phase = (state == ST_FETCH) || mem_op;

    assign read  = !done && ((state == ST_FETCH) || (state == ST_EXEC && opcode == OP_LW));
    assign write = !done && (state == ST_EXEC) && (opcode == OP_SW);
    assign accept = (read || write) && !waitrequest;

    assign address    = mem_op ? alu_result : pc;
    assign writedata  = store_data;
    assign byteenable = {(`MIPS_WORD_W/8){1'b1}}; // Word transfers only.

    // Set on reset too, which holds the first fetch back by one cycle.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            done <= 1'b1;
        end else begin
            done <= accept;
        end
    end

    // Pending also during the post-reset cycle, until the request is taken.
    assign bus_busy = req_phase && !accept;

    // Read data arrives in writeback, one cycle after the load was accepted.
    assign load_data = readdata;

endmodule

// File: mips_cpu_bus.sv
`timescale 1ns/1ps
`include "mips_consts.svh"

module mips_cpu_bus (
    input  logic                    clk,
    input  logic                    rst_n,
    output logic                    active,
    output logic [`MIPS_WORD_W-1:0] register_v0,

    // Avalon-MM master.
    output logic [`MIPS_WORD_W-1:0] address,
    output logic                    write,
    output logic                    read,
    input  logic                    waitrequest,
    output logic [`MIPS_WORD_W-1:0] writedata,
    output logic [3:0]              byteenable,
    input  logic [`MIPS_WORD_W-1:0] readdata
);
    import mips_pkg::*;

    cpu_state_t              state;
    opcode_t                 opcode;
    logic                    halted, halt_req, bus_busy, wb_en, equal;
    logic [4:0]              rs_idx, rt_idx, wb_idx, shamt;
    logic [25:0]             jump_index;
    logic [`MIPS_WORD_W-1:0] imm_sext, imm_zext, rs_data, rt_data;
    logic [`MIPS_WORD_W-1:0] alu_result, load_data, pc, wb_data;

    assign active = ~halted;

    // Writeback source select.
    always_comb begin
        case (opcode)
            OP_LW:   wb_data = load_data;
            OP_LUI:  wb_data = {imm_zext[15:0], 16'h0000};
            default: wb_data = alu_result;
        endcase
    end

    cpu_control u_control (
        .clk(clk), .rst_n(rst_n), .bus_busy(bus_busy), .halt_req(halt_req),
        .state(state), .halted(halted)
    );

    instr_decode u_decode (
        .clk(clk), .rst_n(rst_n), .state(state), .readdata(readdata), .opcode(opcode),
        .rs_idx(rs_idx), .rt_idx(rt_idx), .wb_idx(wb_idx), .wb_en(wb_en),
        .imm_sext(imm_sext), .imm_zext(imm_zext), .shamt(shamt), .jump_index(jump_index)
    );

    mips_alu u_alu (
        .opcode(opcode), .rs_data(rs_data), .rt_data(rt_data), .imm_sext(imm_sext),
        .imm_zext(imm_zext), .shamt(shamt), .result(alu_result), .equal(equal)
    );

    mips_regfile u_regfile (
        .clk(clk), .rst_n(rst_n), .wr_en(wb_en && (state == ST_WRITEBACK)),
        .wr_idx(wb_idx), .wr_data(wb_data), .rd_a_idx(rs_idx), .rd_b_idx(rt_idx),
        .rd_a_data(rs_data), .rd_b_data(rt_data), .v0(register_v0)
    );

    pc_unit u_pc (
        .clk(clk), .rst_n(rst_n), .state(state), .opcode(opcode), .imm_sext(imm_sext),
        .jump_index(jump_index), .rs_data(rs_data), .equal(equal), .pc(pc),
        .halt_req(halt_req)
    );

    mem_access u_mem (
        .clk(clk), .rst_n(rst_n), .state(state), .opcode(opcode), .pc(pc),
        .alu_result(alu_result), .store_data(rt_data), .waitrequest(waitrequest),
        .readdata(readdata), .address(address), .read(read), .write(write),
        .writedata(writedata), .byteenable(byteenable), .load_data(load_data),
        .bus_busy(bus_busy)
    );

endmodule

// File: tb_avalon_mem.sv
`timescale 1ns/1ps

module tb_avalon_mem (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        stall_en,
    input  logic [31:0] address,
    input  logic        read,
    input  logic        write,
    input  logic [31:0] writedata,
    output logic        waitrequest,
    output logic [31:0] readdata
);
    logic [31:0] prog [64];
    logic [31:0] data [64];
    logic [31:0] rng;
    logic [1:0]  wait_run;
    logic        stall;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    initial begin
        waitrequest = 1'b0;
        readdata    = '0;
    end

    // At most three stall cycles in a row.
    assign stall = stall_en && rng[3] && (wait_run != 2'd3);

    always @(posedge clk) begin
        if (!rst_n) begin
            rng         <= 32'h80ab;
            wait_run    <= 2'd0;
            waitrequest <= 1'b0;
        end else begin
            rng         <= xorshift(rng);
            waitrequest <= stall;
            wait_run    <= stall ? wait_run + 2'd1 : 2'd0;
        end
        // One cycle read latency. Program space sits at the top nibble B.
        if (read && !waitrequest) begin
            readdata <= (address[31:28] == 4'hB) ? prog[address[7:2]] : data[address[7:2]];
        end
        if (write && !waitrequest) begin
            data[address[7:2]] <= writedata;
        end
    end

endmodule

// File: tb_mips_cpu_bus.sv
`timescale 1ns/1ps
`include "mips_consts.svh"

module tb_mips_cpu_bus;

    localparam logic [4:0]  V0 = `MIPS_REG_V0;
    localparam logic [4:0]  T0 = 5'd8, T1 = 5'd9, T2 = 5'd10, T3 = 5'd11, S0 = 5'd16;
    localparam logic [15:0] A_HI = 16'h1234, A_LO = 16'h5678, B_IMM = 16'hFF9C;
    localparam logic [15:0] C_IMM = 16'hF0F7, D_IMM = 16'h3C5A, MARK = 16'hDEAD;
    localparam logic [15:0] D_HI = 16'h1001;
    localparam logic [4:0]  SH_L = 5'd4, SH_R = 5'd3;
    localparam logic [31:0] D_BASE = {D_HI, 16'h0000};
    localparam int          RESET_CYCLES = 3;
    // 27 executed instructions and 31 transfers, each stalled up to 3 cycles.
    localparam int          WORST_CYCLES = 27 * 4 + 31 * 3 + 4;

    logic        clk, rst_n, stall_en, active, read, write, waitrequest;
    logic [31:0] register_v0, address, writedata, readdata;
    logic [3:0]  byteenable;
    logic        rst_q = 1'b1;
    logic        armed = 1'b0;
    logic        halted, first_read, req_q, wait_q, read_q, write_q;
    logic [31:0] addr_q, wdata_q, first_v0;
    logic [31:0] exp_addr [2];
    logic [31:0] exp_data [2];
    int          errors, wr_count, wr_total;

    mips_cpu_bus uut (
        .clk(clk), .rst_n(rst_n), .active(active), .register_v0(register_v0),
        .address(address), .write(write), .read(read), .waitrequest(waitrequest),
        .writedata(writedata), .byteenable(byteenable), .readdata(readdata)
    );

    tb_avalon_mem ram (
        .clk(clk), .rst_n(rst_n), .stall_en(stall_en), .address(address), .read(read),
        .write(write), .writedata(writedata), .waitrequest(waitrequest), .readdata(readdata)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] r_word(input logic [5:0] funct,
                                           input logic [4:0] rs, rt, rd, sh);
        return {6'h00, rs, rt, rd, sh, funct};
    endfunction

    function automatic logic [31:0] i_word(input logic [5:0] op, input logic [4:0] rs, rt,
                                           input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // Data fill that differs for every word address.
    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return {addr[15:0], addr[31:16]} ^ 32'hA5C3_5A3C;
    endfunction

    task automatic report(input string msg);
        errors++;
        $display("ERROR %0t: %s", $time, msg);
    endtask

    // Builds the program, the data image and the expected writes.
    task automatic load_image();
        logic [31:0] a, b, v, jump_target;
        a = {A_HI, A_LO};
        b = {{16{B_IMM[15]}}, B_IMM};
        jump_target = `MIPS_RESET_VECTOR + 32'd27 * 4;
        for (int i = 0; i < 64; i++) begin
            ram.prog[i] = 32'h0000_0000;
            ram.data[i] = fill_word(D_BASE + 4 * i);
        end
        ram.prog[0]  = i_word(6'h0F, 5'd0, T0, A_HI);  // LUI t0.
        ram.prog[1]  = i_word(6'h0D, T0, T0, A_LO);    // ORI t0.
        ram.prog[2]  = i_word(6'h09, 5'd0, T1, B_IMM); // ADDIU t1.
        ram.prog[3]  = r_word(6'h21, T0, T1, V0, 5'd0);  // ADDU.
        ram.prog[4]  = r_word(6'h26, V0, T0, V0, 5'd0);  // XOR.
        ram.prog[5]  = r_word(6'h23, V0, T1, V0, 5'd0);  // SUBU.
        ram.prog[6]  = r_word(6'h25, V0, T0, V0, 5'd0);  // OR.
        ram.prog[7]  = r_word(6'h24, V0, T1, V0, 5'd0);  // AND.
        ram.prog[8]  = r_word(6'h00, 5'd0, V0, V0, SH_L); // SLL.
        ram.prog[9]  = r_word(6'h02, 5'd0, V0, V0, SH_R); // SRL.
        ram.prog[10] = r_word(6'h2A, T1, T0, T2, 5'd0);  // SLT.
        ram.prog[11] = r_word(6'h21, V0, T2, V0, 5'd0);
        ram.prog[12] = r_word(6'h2B, T0, T1, T2, 5'd0);  // SLTU.
        ram.prog[13] = r_word(6'h21, V0, T2, V0, 5'd0);
        ram.prog[14] = i_word(6'h0C, V0, V0, C_IMM);   // ANDI.
        ram.prog[15] = i_word(6'h0E, V0, V0, D_IMM);   // XORI.
        ram.prog[16] = i_word(6'h0F, 5'd0, S0, D_HI);  // Data base.
        ram.prog[17] = i_word(6'h2B, S0, V0, 16'd0);   // SW v0.
        ram.prog[18] = i_word(6'h23, S0, T3, 16'd0);   // LW it back.
        ram.prog[19] = i_word(6'h04, T3, V0, 16'd1);   // BEQ, taken.
        ram.prog[20] = i_word(6'h0D, 5'd0, V0, MARK);
        ram.prog[21] = i_word(6'h05, T3, V0, 16'd1);   // BNE, not taken.
        ram.prog[22] = i_word(6'h23, S0, T2, 16'd4);   // LW fill word.
        ram.prog[23] = i_word(6'h05, T2, V0, 16'd1);   // BNE, taken.
        ram.prog[24] = i_word(6'h0D, 5'd0, V0, MARK);
        ram.prog[25] = {6'h02, jump_target[27:2]};     // J over the marker.
        ram.prog[26] = i_word(6'h0D, 5'd0, V0, MARK);
        ram.prog[27] = r_word(6'h26, V0, T2, V0, 5'd0);
        ram.prog[28] = i_word(6'h2B, S0, V0, 16'd8);   // SW final v0.
        ram.prog[29] = r_word(6'h08, 5'd0, 5'd0, 5'd0, 5'd0); // JR r0 halts.
        v = ((((a + b) ^ a) - b) | a) & b;
        v = (v << SH_L) >> SH_R;
        v = v + {31'd0, $signed(b) < $signed(a)} + {31'd0, a < b};
        v = (v & {16'h0000, C_IMM}) ^ {16'h0000, D_IMM};
        exp_addr[0] = D_BASE;
        exp_data[0] = v;
        exp_addr[1] = D_BASE + 32'd8;
        exp_data[1] = v ^ fill_word(D_BASE + 32'd4);
    endtask

    // Samples on the rising edge, before the DUT updates.
    always @(posedge clk) begin
        if (!rst_q) begin
            assert (!read && !write && active) else report("bus busy or core inactive in reset");
        end
        if (armed) begin
            assert (!(read && write)) else report("read and write high together");
        end
        if (req_q && wait_q) begin
            assert (read == read_q && write == write_q && address == addr_q
                    && writedata == wdata_q) else report("request changed under waitrequest");
        end
        if (halted) begin
            assert (!read && !write && !active) else report("bus request or active after halt");
        end
        if (read && !waitrequest && first_read) begin
            assert (address == `MIPS_RESET_VECTOR) else report("first fetch not at reset vector");
        end
        if (write && !waitrequest) begin
            assert (wr_count < 2 && byteenable == 4'hF && address == exp_addr[wr_count]
                    && writedata == exp_data[wr_count]) else report("unexpected bus write");
            wr_count <= wr_count + 1;
            wr_total <= wr_total + 1;
        end
        armed   <= 1'b1;
        rst_q   <= rst_n;
        req_q   <= read || write;
        wait_q  <= waitrequest;
        read_q  <= read;
        write_q <= write;
        addr_q  <= address;
        wdata_q <= writedata;
        if (!rst_n) begin
            halted     <= 1'b0;
            first_read <= 1'b1;
            wr_count   <= 0;
        end else begin
            if (!active) halted <= 1'b1;
            if (read && !waitrequest) first_read <= 1'b0;
        end
    end

    task automatic run_program(input logic stalls);
        stall_en <= stalls;
        rst_n    <= 1'b0;
        load_image();
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        wait (active === 1'b0);
        repeat (4) @(posedge clk); // Let the monitor see the halted bus.
        assert (register_v0 == exp_data[1]) else report("register_v0 differs from expected");
        assert (wr_count == 2) else report("wrong number of bus writes");
    endtask

    initial begin
        rst_n    = 1'b0;
        stall_en = 1'b0;
        errors   = 0;
        wr_total = 0;
        run_program(1'b0);
        first_v0 = register_v0;
        run_program(1'b1);
        assert (register_v0 == first_v0) else report("stalled run ended with other register_v0");
        $display("Runs: 2, bus writes: %0d, errors: %0d", wr_total, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    initial begin
        #(2 * 2 * (WORST_CYCLES + RESET_CYCLES + 5) * 100);
        $display("Watchdog timeout, the core did not halt in time");
        $display("TESTS FAILED");
        $finish;
    end

endmodule

// File: filelist.f
+incdir+.
mips_pkg.sv
cpu_control.sv
instr_decode.sv
mips_alu.sv
mips_regfile.sv
pc_unit.sv
mem_access.sv
mips_cpu_bus.sv
tb_avalon_mem.sv
tb_mips_cpu_bus.sv
